/* src/fcore_pkg.sv */
// Fixed-point core shared definitions
`default_nettype none

package fcore_pkg;

    // Datapath word and register file geometry
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int IMM_WIDTH      = 16;
    localparam int NUM_REGS       = 2 ** REG_ADDR_WIDTH;

    // Codes 10 to 15 are unassigned and execute as a zero result
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_MUL = 4'd3,
        OP_MAC = 4'd4,
        OP_AND = 4'd5,
        OP_OR  = 4'd6,
        OP_XOR = 4'd7,
        OP_SLT = 4'd8,
        OP_LDI = 4'd9
    } opcode_e;

    // Instruction word as presented by the sequencer, 32 bits in total
    typedef struct packed {
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [REG_ADDR_WIDTH-1:0] src_a;
        logic [REG_ADDR_WIDTH-1:0] src_b;
        logic [IMM_WIDTH-1:0]      imm;
    } instr_t;

    // Operands resolved by the fetch stage
    // operand_c carries the old destination value for MAC
    typedef struct packed {
        logic                      valid;
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     operand_a;
        logic [DATA_WIDTH-1:0]     operand_b;
        logic [DATA_WIDTH-1:0]     operand_c;
    } issue_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     data;
        logic                      overflow;
    } result_t;

endpackage

`default_nettype wire

/* src/register_file.sv */
// Core register file
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire  [fcore_pkg::REG_ADDR_WIDTH-1:0] rd_addr_a,
    input  wire  [fcore_pkg::REG_ADDR_WIDTH-1:0] rd_addr_b,
    input  wire  [fcore_pkg::REG_ADDR_WIDTH-1:0] rd_addr_c,
    output logic [fcore_pkg::DATA_WIDTH-1:0]     rd_data_a,
    output logic [fcore_pkg::DATA_WIDTH-1:0]     rd_data_b,
    output logic [fcore_pkg::DATA_WIDTH-1:0]     rd_data_c,
    input  wire                                  wr_en,
    input  wire  [fcore_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0]     wr_data
);
    import fcore_pkg::*;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    // Every register starts at zero, so a read before any write returns 0
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the stored contents only
    // A write in the same cycle becomes visible after the edge
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign rd_data_c = regs[rd_addr_c];

endmodule

`default_nettype wire

/* src/operand_fetch.sv */
// Instruction decode and operand fetch
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire                                  instr_valid,
    input  fcore_pkg::instr_t                    instr,
    output logic [fcore_pkg::REG_ADDR_WIDTH-1:0] rd_addr_a,
    output logic [fcore_pkg::REG_ADDR_WIDTH-1:0] rd_addr_b,
    output logic [fcore_pkg::REG_ADDR_WIDTH-1:0] rd_addr_c,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0]     rd_data_a,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0]     rd_data_b,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0]     rd_data_c,
    output fcore_pkg::issue_t                    issue
);
    import fcore_pkg::*;

    logic [DATA_WIDTH-1:0] imm_ext;
    issue_t                issue_next;

    // Port c reads the destination so MAC can accumulate onto it
    assign rd_addr_a = instr.src_a;
    assign rd_addr_b = instr.src_b;
    assign rd_addr_c = instr.dest;

    assign imm_ext = {{(DATA_WIDTH - IMM_WIDTH){instr.imm[IMM_WIDTH-1]}}, instr.imm};

    always_comb begin
        issue_next.valid     = instr_valid && (instr.opcode != OP_NOP);
        issue_next.opcode    = instr.opcode;
        issue_next.dest      = instr.dest;
        // LDI routes its immediate through the a operand
        issue_next.operand_a = (instr.opcode == OP_LDI) ? imm_ext : rd_data_a;
        issue_next.operand_b = rd_data_b;
        issue_next.operand_c = rd_data_c;
    end

    // One register stage between the sequencer and the execution pipeline
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue <= '0;
        end else begin
            issue <= issue_next;
        end
    end

endmodule

`default_nettype wire

/* src/fixed_alu.sv */
// Pipelined integer ALU
`timescale 1ns/1ps
`default_nettype none

module fixed_alu #(
    parameter int PIPELINE_DEPTH = 3
) (
    input  wire                              clock,
    input  wire                              arst_n,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0] operand_a,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0] operand_b,
    input  wire  [fcore_pkg::DATA_WIDTH-1:0] operand_c,
    input  fcore_pkg::opcode_e               opcode,
    input  fcore_pkg::opcode_e               result_select,
    output logic [fcore_pkg::DATA_WIDTH-1:0] data,
    output logic                             overflow
);
    import fcore_pkg::*;

    localparam int HALF = DATA_WIDTH / 2;

    // Candidates that are complete after the first stage
    typedef struct packed {
        logic [DATA_WIDTH-1:0] sum;
        logic [DATA_WIDTH-1:0] diff;
        logic [DATA_WIDTH-1:0] and_r;
        logic [DATA_WIDTH-1:0] or_r;
        logic [DATA_WIDTH-1:0] xor_r;
        logic [DATA_WIDTH-1:0] pass_a;
        logic                  slt;
        logic                  add_ovf;
        logic                  sub_ovf;
    } early_t;

    // Partial products and the accumulate term of the multiplier
    typedef struct packed {
        logic [DATA_WIDTH-1:0] p_low;
        logic [HALF-1:0]       cross_lo;
        logic [DATA_WIDTH-1:0] addend;
    } mul_part_t;

    typedef struct packed {
        early_t                early;
        logic [DATA_WIDTH-1:0] mul_acc;
    } cand_t;

    logic                  mul_en;
    logic [DATA_WIDTH-1:0] mul_a;
    logic [DATA_WIDTH-1:0] mul_b;
    early_t                early_next;
    mul_part_t             mul_next;
    early_t                s1_early;
    mul_part_t             s1_mul;
    cand_t                 pipe [2:PIPELINE_DEPTH];

    // Multiplier inputs are held at zero unless a multiply is issued,
    // and the addend is zero for MUL so MUL and MAC share one candidate
    assign mul_en = (opcode == OP_MUL) || (opcode == OP_MAC);
    assign mul_a  = mul_en ? operand_a : '0;
    assign mul_b  = mul_en ? operand_b : '0;

    always_comb begin
        early_next.sum     = operand_a + operand_b;
        early_next.diff    = operand_a - operand_b;
        early_next.and_r   = operand_a & operand_b;
        early_next.or_r    = operand_a | operand_b;
        early_next.xor_r   = operand_a ^ operand_b;
        early_next.pass_a  = operand_a;
        early_next.slt     = $signed(operand_a) < $signed(operand_b);
        // Signed overflow flips the sign away from equally signed inputs
        early_next.add_ovf = (operand_a[DATA_WIDTH-1] == operand_b[DATA_WIDTH-1]) &&
                             (early_next.sum[DATA_WIDTH-1] != operand_a[DATA_WIDTH-1]);
        early_next.sub_ovf = (operand_a[DATA_WIDTH-1] != operand_b[DATA_WIDTH-1]) &&
                             (early_next.diff[DATA_WIDTH-1] != operand_a[DATA_WIDTH-1]);

        // Only the low word of the product is kept, so the high by high term
        // drops out and the cross terms matter only in their low half
        mul_next.p_low    = mul_a[HALF-1:0] * mul_b[HALF-1:0];
        mul_next.cross_lo = mul_a[DATA_WIDTH-1:HALF] * mul_b[HALF-1:0] +
                            mul_a[HALF-1:0] * mul_b[DATA_WIDTH-1:HALF];
        mul_next.addend   = (opcode == OP_MAC) ? operand_c : '0;
    end

    // Stage 1 registers, then stage 2 finishes the product and the MAC sum
    // Later stages only carry the candidates to keep the depth
    always_ff @(posedge clock) begin
        s1_early <= early_next;
        s1_mul   <= mul_next;
        pipe[2].early   <= s1_early;
        pipe[2].mul_acc <= s1_mul.p_low + {s1_mul.cross_lo, {HALF{1'b0}}} + s1_mul.addend;
        for (int k = 3; k <= PIPELINE_DEPTH; k++) begin
            pipe[k] <= pipe[k-1];
        end
    end

    // Output stage, result_select is aligned with the last candidate stage
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            data     <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            case (result_select)
                OP_ADD: begin
                    data     <= pipe[PIPELINE_DEPTH].early.sum;
                    overflow <= pipe[PIPELINE_DEPTH].early.add_ovf;
                end
                OP_SUB: begin
                    data     <= pipe[PIPELINE_DEPTH].early.diff;
                    overflow <= pipe[PIPELINE_DEPTH].early.sub_ovf;
                end
                OP_MUL, OP_MAC: data <= pipe[PIPELINE_DEPTH].mul_acc;
                OP_AND: data <= pipe[PIPELINE_DEPTH].early.and_r;
                OP_OR:  data <= pipe[PIPELINE_DEPTH].early.or_r;
                OP_XOR: data <= pipe[PIPELINE_DEPTH].early.xor_r;
                OP_SLT: data <= {{(DATA_WIDTH - 1){1'b0}}, pipe[PIPELINE_DEPTH].early.slt};
                OP_LDI: data <= pipe[PIPELINE_DEPTH].early.pass_a;
                default: data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/exec_stage.sv */
// Execution stage with control delay line
`timescale 1ns/1ps
`default_nettype none

module exec_stage #(
    parameter int PIPELINE_DEPTH = 3
) (
    input  wire               clock,
    input  wire               arst_n,
    input  fcore_pkg::issue_t issue,
    output fcore_pkg::result_t result
);
    import fcore_pkg::*;

    // Control fields that follow an operation through the ALU
    typedef struct packed {
        logic                      valid;
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] dest;
    } ctrl_t;

    ctrl_t                 dly [PIPELINE_DEPTH];
    ctrl_t                 tail;
    logic [DATA_WIDTH-1:0] alu_data;
    logic                  alu_overflow;

    // Entry k holds the control of the operation in ALU stage k+1
    // The tail lines up with the registered ALU output
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PIPELINE_DEPTH; i++) begin
                dly[i] <= '0;
            end
            tail <= '0;
        end else begin
            dly[0] <= '{valid: issue.valid, opcode: issue.opcode, dest: issue.dest};
            for (int i = 1; i < PIPELINE_DEPTH; i++) begin
                dly[i] <= dly[i-1];
            end
            tail <= dly[PIPELINE_DEPTH-1];
        end
    end

    fixed_alu #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) fixed_alu_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .operand_a    (issue.operand_a),
        .operand_b    (issue.operand_b),
        .operand_c    (issue.operand_c),
        .opcode       (issue.opcode),
        .result_select(dly[PIPELINE_DEPTH-1].opcode),
        .data         (alu_data),
        .overflow     (alu_overflow)
    );

    assign result = '{valid: tail.valid, dest: tail.dest, data: alu_data,
                      overflow: alu_overflow};

endmodule

`default_nettype wire

/* src/writeback.sv */
// Result writeback and status
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  fcore_pkg::result_t                   result_in,
    input  wire                                  clear_status,
    output logic                                 wr_en,
    output logic [fcore_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
    output logic [fcore_pkg::DATA_WIDTH-1:0]     wr_data,
    output fcore_pkg::result_t                   result_out,
    output logic                                 overflow
);
    import fcore_pkg::*;

    // The write lands on the same edge that registers result_out
    assign wr_en   = result_in.valid;
    assign wr_addr = result_in.dest;
    assign wr_data = result_in.data;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result_out <= '0;
        end else begin
            result_out <= result_in;
        end
    end

    // Sticky flag, a new overflow takes priority over a clear in the same cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (result_in.valid && result_in.overflow) begin
            overflow <= 1'b1;
        end else if (clear_status) begin
            overflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/fcore_top.sv */
// Fixed-point execution core top level
`timescale 1ns/1ps
`default_nettype none

module fcore_top #(
    // Minimum depth is 2, the multiplier needs two stages
    parameter int PIPELINE_DEPTH = 3
) (
    input  wire                clock,
    input  wire                arst_n,
    input  wire                instr_valid,
    input  fcore_pkg::instr_t  instr,
    input  wire                clear_status,
    output fcore_pkg::result_t result,
    output logic               overflow
);
    import fcore_pkg::*;

    logic [REG_ADDR_WIDTH-1:0] rd_addr_a;
    logic [REG_ADDR_WIDTH-1:0] rd_addr_b;
    logic [REG_ADDR_WIDTH-1:0] rd_addr_c;
    logic [DATA_WIDTH-1:0]     rd_data_a;
    logic [DATA_WIDTH-1:0]     rd_data_b;
    logic [DATA_WIDTH-1:0]     rd_data_c;
    logic                      wr_en;
    logic [REG_ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0]     wr_data;
    issue_t                    issue;
    result_t                   exec_result;

    register_file register_file_inst (
        .clock    (clock),
        .arst_n   (arst_n),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_addr_c(rd_addr_c),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .rd_data_c(rd_data_c),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    operand_fetch operand_fetch_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_addr_c  (rd_addr_c),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .rd_data_c  (rd_data_c),
        .issue      (issue)
    );

    exec_stage #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) exec_stage_inst (
        .clock (clock),
        .arst_n(arst_n),
        .issue (issue),
        .result(exec_result)
    );

    writeback writeback_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .result_in   (exec_result),
        .clear_status(clear_status),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .result_out  (result),
        .overflow    (overflow)
    );

endmodule

`default_nettype wire

/* test/tb_fcore.sv */
// Fixed-point core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fcore;
    import fcore_pkg::*;

    localparam int PIPELINE_DEPTH = 3;
    localparam int CLOCK_PERIOD   = 20;
    localparam int NUM_BURST      = 300;
    // Distance in edges between a write issue and the first issue that may read it
    localparam int HAZARD_GAP     = PIPELINE_DEPTH + 4;
    // Burst slots can carry one extra cycle and directed steps can stall a full gap
    localparam int WATCHDOG_CYCLES = 2 * NUM_BURST + 40 * (HAZARD_GAP + 2) + PIPELINE_DEPTH + 102;
    localparam longint MAX_S32 = 64'sh7fff_ffff;
    localparam longint MIN_S32 = -64'sh8000_0000;

    // One outstanding result as predicted at issue time
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     data;
        logic                      overflow;
        int                        issue_cycle;
    } expect_t;

    logic    clock;
    logic    arst_n;
    logic    instr_valid;
    instr_t  instr;
    logic    clear_status;
    result_t result;
    logic    overflow;

    int                    seed;
    int                    cycle = 0;
    int                    last_write [NUM_REGS];
    logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
    expect_t               expected_q [$];
    logic                  clear_seen = 1'b0;
    logic                  sticky_ovf = 1'b0;

    fcore_top #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) fcore_top_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .clear_status(clear_status),
        .result      (result),
        .overflow    (overflow)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Counts rising edges so an instruction driven now is sampled at edge cycle+1
    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Clear as the DUT saw it on the last rising edge
    always @(posedge clock) begin
        clear_seen <= clear_status;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s actual=0x%0h expected=0x%0h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Expected {overflow, data} worked out with 64-bit signed arithmetic
    function automatic logic [DATA_WIDTH:0] ref_result(input opcode_e op,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
            input logic [DATA_WIDTH-1:0] c, input logic [IMM_WIDTH-1:0] imm);
        longint                sa;
        longint                sb;
        longint                wide;
        logic [DATA_WIDTH-1:0] value;
        logic                  ovf;
        sa    = longint'($signed(a));
        sb    = longint'($signed(b));
        wide  = 0;
        value = '0;
        ovf   = 1'b0;
        case (op)
            OP_ADD: begin
                wide  = sa + sb;
                value = wide[DATA_WIDTH-1:0];
                ovf   = (wide > MAX_S32) || (wide < MIN_S32);
            end
            OP_SUB: begin
                wide  = sa - sb;
                value = wide[DATA_WIDTH-1:0];
                ovf   = (wide > MAX_S32) || (wide < MIN_S32);
            end
            OP_MUL: begin
                wide  = sa * sb;
                value = wide[DATA_WIDTH-1:0];
            end
            OP_MAC: begin
                wide  = sa * sb + longint'(c);
                value = wide[DATA_WIDTH-1:0];
            end
            OP_AND: value = a & b;
            OP_OR:  value = a | b;
            OP_XOR: value = a ^ b;
            OP_SLT: value = (sa < sb) ? 32'd1 : 32'd0;
            OP_LDI: begin
                wide  = longint'($signed(imm));
                value = wide[DATA_WIDTH-1:0];
            end
            default: value = '0;
        endcase
        return {ovf, value};
    endfunction

    function automatic bit reg_settled(input logic [REG_ADDR_WIDTH-1:0] r);
        return (cycle + 1 - last_write[r]) >= HAZARD_GAP;
    endfunction

    // MAC also reads its destination through port c
    function automatic bit sources_ready(input opcode_e op,
            input logic [REG_ADDR_WIDTH-1:0] dest_reg, input logic [REG_ADDR_WIDTH-1:0] reg_a,
            input logic [REG_ADDR_WIDTH-1:0] reg_b);
        if (op == OP_NOP || op == OP_LDI) begin
            return 1'b1;
        end
        if (op == OP_MAC) begin
            return reg_settled(reg_a) && reg_settled(reg_b) && reg_settled(dest_reg);
        end
        return reg_settled(reg_a) && reg_settled(reg_b);
    endfunction

    // Scan from a random start for a register with no write in flight
    function automatic logic [REG_ADDR_WIDTH-1:0] pick_safe_reg();
        int                        start;
        logic [REG_ADDR_WIDTH-1:0] r;
        start = $unsigned($random(seed)) % NUM_REGS;
        for (int k = 0; k < NUM_REGS; k++) begin
            r = REG_ADDR_WIDTH'((start + k) % NUM_REGS);
            if (reg_settled(r)) begin
                return r;
            end
        end
        return REG_ADDR_WIDTH'(start);
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            instr_valid  = 1'b0;
            clear_status = 1'b0;
        end
    endtask

    // Clear is high for one cycle and dropped by whichever task drives next
    task automatic pulse_clear();
        @(negedge clock);
        instr_valid  = 1'b0;
        clear_status = 1'b1;
    endtask

    // Stalls while a source is still being written and then strobes the instruction
    task automatic issue_instr(input opcode_e op, input logic [REG_ADDR_WIDTH-1:0] dest_reg,
            input logic [REG_ADDR_WIDTH-1:0] reg_a, input logic [REG_ADDR_WIDTH-1:0] reg_b,
            input logic [IMM_WIDTH-1:0] imm);
        logic [DATA_WIDTH:0] expected;
        expect_t             item;
        @(negedge clock);
        while (!sources_ready(op, dest_reg, reg_a, reg_b)) begin
            instr_valid  = 1'b0;
            clear_status = 1'b0;
            @(negedge clock);
        end
        instr_valid  = 1'b1;
        clear_status = 1'b0;
        instr        = '{opcode: op, dest: dest_reg, src_a: reg_a, src_b: reg_b, imm: imm};
        if (op != OP_NOP) begin
            expected = ref_result(op, model_regs[reg_a], model_regs[reg_b],
                                  model_regs[dest_reg], imm);
            item = '{dest: dest_reg, data: expected[DATA_WIDTH-1:0],
                     overflow: expected[DATA_WIDTH], issue_cycle: cycle + 1};
            expected_q.push_back(item);
            model_regs[dest_reg] = expected[DATA_WIDTH-1:0];
            last_write[dest_reg] = cycle + 1;
        end
    endtask

    // Compares each result on the falling edge where the outputs are stable
    always @(negedge clock) begin
        expect_t item;
        logic    set_now;
        set_now = 1'b0;
        if (arst_n) begin
            if (result.valid) begin
                if (expected_q.size() == 0) begin
                    $display("Result strobe at %0t with no instruction outstanding", $time);
                    $display(">>> FAIL");
                    $fatal(1);
                end else begin
                    item = expected_q.pop_front();
                    check_value("result.dest", 32'(result.dest), 32'(item.dest));
                    check_value("result.data", result.data, item.data);
                    check_value("result.overflow", 32'(result.overflow), 32'(item.overflow));
                    check_value("result latency", 32'(cycle - item.issue_cycle),
                                32'(PIPELINE_DEPTH + 2));
                    set_now = item.overflow;
                end
            end
            // A setting result wins over a clear on the same edge
            if (set_now) begin
                sticky_ovf = 1'b1;
            end else if (clear_seen) begin
                sticky_ovf = 1'b0;
            end
            check_value("overflow", 32'(overflow), 32'(sticky_ovf));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        logic [31:0] draw;
        int          op_idx;
        clock        = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        clear_status = 1'b0;
        seed         = 32'h2bdce1f3;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
            last_write[r] = -HAZARD_GAP;
        end
        repeat (4) @(negedge clock);
        arst_n = 1'b1;

        // A quiet period and then operations on registers that still hold zero
        idle(8);
        issue_instr(OP_ADD, 4'd1, 4'd2, 4'd3, 16'h0000);
        issue_instr(OP_MAC, 4'd4, 4'd5, 4'd6, 16'h0000);
        idle(HAZARD_GAP);

        // Fill every register with a random immediate in back to back slots
        for (int r = 0; r < NUM_REGS; r++) begin
            issue_instr(OP_LDI, REG_ADDR_WIDTH'(r), 4'd0, 4'd0, IMM_WIDTH'($random(seed)));
        end

        // Random burst with NOPs, idle slots and stray clears mixed in
        for (int n = 0; n < NUM_BURST; n++) begin
            draw = $random(seed);
            if (draw[3:0] == 4'd0) begin
                idle(1);
            end else if (draw[3:0] == 4'd1) begin
                pulse_clear();
            end
            op_idx = $unsigned($random(seed)) % 10;
            issue_instr(opcode_e'(op_idx[3:0]), pick_safe_reg(), pick_safe_reg(),
                        pick_safe_reg(), IMM_WIDTH'($random(seed)));
        end
        idle(HAZARD_GAP);

        // Doubling 2^28 three times carries the last sum into the sign bit
        pulse_clear();
        issue_instr(OP_LDI, 4'd1, 4'd0, 4'd0, 16'h4000);
        issue_instr(OP_MUL, 4'd2, 4'd1, 4'd1, 16'h0000);
        issue_instr(OP_ADD, 4'd3, 4'd2, 4'd2, 16'h0000);
        issue_instr(OP_ADD, 4'd4, 4'd3, 4'd3, 16'h0000);
        issue_instr(OP_ADD, 4'd5, 4'd4, 4'd4, 16'h0000);
        idle(HAZARD_GAP);
        check_value("overflow", 32'(overflow), 32'd1);

        // Results without overflow leave the flag alone
        issue_instr(OP_LDI, 4'd6, 4'd0, 4'd0, 16'd5);
        issue_instr(OP_ADD, 4'd7, 4'd6, 4'd6, 16'h0000);
        idle(HAZARD_GAP);
        check_value("overflow", 32'(overflow), 32'd1);
        pulse_clear();
        idle(1);
        check_value("overflow", 32'(overflow), 32'd0);

        // Clear lands on the same edge as the overflowing result
        issue_instr(OP_ADD, 4'd5, 4'd4, 4'd4, 16'h0000);
        idle(PIPELINE_DEPTH + 1);
        pulse_clear();
        idle(1);
        check_value("overflow", 32'(overflow), 32'd1);

        idle(HAZARD_GAP);
        if (expected_q.size() != 0) begin
            $display("%0d results never arrived by the end of the run", expected_q.size());
            $display(">>> FAIL");
            $fatal(1);
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
src/fcore_pkg.sv
src/register_file.sv
src/operand_fetch.sv
src/fixed_alu.sv
src/exec_stage.sv
src/writeback.sv
src/fcore_top.sv
test/tb_fcore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fcore
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
